// File: wb_pkg.sv
package wb_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_NUM_W  = 14;
  localparam int ECODE_W    = 6;
  localparam int ESUBCODE_W = 9;

  // implemented csr numbers, anything else reads as zero
  typedef enum logic [CSR_NUM_W-1:0] {
    CSR_CRMD   = 14'h0,
    CSR_PRMD   = 14'h1,
    CSR_ECFG   = 14'h4,
    CSR_ESTAT  = 14'h5,
    CSR_ERA    = 14'h6,
    CSR_BADV   = 14'h7,
    CSR_EENTRY = 14'hc
  } csr_addr_e;

  // every op returns the old csr value to rd
  typedef enum logic [1:0] {
    CSR_OP_NONE,
    CSR_OP_RD,
    CSR_OP_WR,
    CSR_OP_XCHG   // write under mask from rj
  } csr_op_e;

  typedef enum logic [ECODE_W-1:0] {
    ECODE_INT = 6'h0,
    ECODE_ADE = 6'h8,   // esubcode 0 fetch, 1 memory access
    ECODE_ALE = 6'h9,
    ECODE_SYS = 6'hb,
    ECODE_BRK = 6'hc,
    ECODE_INE = 6'hd,
    ECODE_IPE = 6'he
  } ecode_e;

  // flags raised by earlier stages
  typedef struct packed {
    logic adef;
    logic sys;
    logic brk;
    logic ine;
    logic ale;
    logic adem;
  } excep_flags_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       inst;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    csr_op_e               csr_op;
    logic [CSR_NUM_W-1:0]  csr_num;
    logic [XLEN-1:0]       rd_val;    // csr write data
    logic [XLEN-1:0]       rj_val;    // xchg mask
    logic                  is_priv;
    logic                  is_ertn;
    logic                  refetch;
    excep_flags_t          excep;
    logic [XLEN-1:0]       mem_addr;
  } mw_bus_t;

  typedef struct packed {
    logic                  excep_en;
    ecode_e                ecode;
    logic [ESUBCODE_W-1:0] esubcode;
    logic                  badv_we;
    logic [XLEN-1:0]       badv;
  } excep_info_t;

  typedef struct packed {
    logic                 we;
    logic [CSR_NUM_W-1:0] num;
    logic [XLEN-1:0]      wdata;
    excep_info_t          excep;
    logic                 ertn;
    logic [XLEN-1:0]      pc;
  } csr_commit_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
    logic [XLEN-1:0]       pc;
  } commit_t;

endpackage

// File: mw_line.sv
module mw_line (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            mw_valid_i,
  input  wb_pkg::mw_bus_t mw_bus_i,
  input  logic            rfb_allowin_i,
  input  logic            flush_i,
  output logic            wb_allowin_o,
  output logic            line_valid_o,
  output wb_pkg::mw_bus_t line_bus_o
);
  import wb_pkg::*;

  logic    valid_q;
  mw_bus_t bus_q;

  // writeback always finishes in one cycle, so only the retire side can stall
  assign wb_allowin_o = !valid_q || rfb_allowin_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;              // kill anything arriving with the flush
    end else if (wb_allowin_o) begin
      valid_q <= mw_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (mw_valid_i && wb_allowin_o) begin
      bus_q <= mw_bus_i;
    end
  end

  assign line_valid_o = valid_q;
  assign line_bus_o   = bus_q;

  // stalled instruction stays put until the retire buffer takes it
  a_hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
    valid_q && !rfb_allowin_i |=> valid_q && $stable(bus_q));

endmodule

// File: excep_arbiter.sv
module excep_arbiter #(
  parameter int XLEN = 32
) (
  input  wb_pkg::excep_flags_t flags_i,
  input  logic                 int_req_i,
  input  logic                 is_priv_i,
  input  logic [1:0]           plv_i,
  input  logic [XLEN-1:0]      pc_i,
  input  logic [XLEN-1:0]      mem_addr_i,
  output wb_pkg::excep_info_t  info_o
);
  import wb_pkg::*;

  logic ipe;

  // privileged op in user mode
  assign ipe = is_priv_i && (plv_i == 2'd3);

  always_comb begin
    info_o          = '0;
    info_o.excep_en = int_req_i || (|flags_i) || ipe;
    info_o.ecode    = ECODE_INT;

    // fixed priority, interrupt first then pipeline order
    if (int_req_i) begin
      info_o.ecode = ECODE_INT;
    end else if (flags_i.adef) begin
      info_o.ecode    = ECODE_ADE;
      info_o.esubcode = '0;
      info_o.badv_we  = 1'b1;
      info_o.badv     = pc_i;       // fetch address is the bad one
    end else if (flags_i.sys) begin
      info_o.ecode = ECODE_SYS;
    end else if (flags_i.brk) begin
      info_o.ecode = ECODE_BRK;
    end else if (flags_i.ine) begin
      info_o.ecode = ECODE_INE;
    end else if (flags_i.ale) begin
      info_o.ecode   = ECODE_ALE;
      info_o.badv_we = 1'b1;
      info_o.badv    = mem_addr_i;
    end else if (flags_i.adem) begin
      info_o.ecode    = ECODE_ADE;
      info_o.esubcode = ESUBCODE_W'(1);   // adem
      info_o.badv_we  = 1'b1;
      info_o.badv     = mem_addr_i;
    end else if (ipe) begin
      info_o.ecode = ECODE_IPE;
    end
  end

endmodule

// File: wb_stage.sv
module wb_stage #(
  parameter int XLEN = 32
) (
  input  logic                         valid_i,
  input  wb_pkg::mw_bus_t              bus_i,
  input  logic                         rfb_allowin_i,
  input  wb_pkg::excep_info_t          info_i,
  input  logic [XLEN-1:0]              csr_rdata_i,
  input  logic [XLEN-1:0]              eentry_i,
  input  logic [XLEN-1:0]              era_i,
  output logic [wb_pkg::CSR_NUM_W-1:0] csr_raddr_o,
  output wb_pkg::csr_commit_t          csr_commit_o,
  output logic                         rf_we_o,
  output logic [wb_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]              rf_wdata_o,
  output logic                         flush_o,
  output logic [XLEN-1:0]              flush_pc_o,
  output wb_pkg::commit_t              commit_o
);
  import wb_pkg::*;

  logic            fire;
  logic            excep_en;
  logic            ertn_en;
  logic            ctl_ok;     // retiring normally, no exception or return
  logic            csr_access;
  logic            csr_wr;
  logic            csr_we;
  logic            refetch;
  logic [XLEN-1:0] csr_wdata;

  assign fire     = valid_i && rfb_allowin_i;
  assign excep_en = fire && info_i.excep_en;
  assign ertn_en  = fire && bus_i.is_ertn && !info_i.excep_en;
  assign ctl_ok   = fire && !info_i.excep_en && !bus_i.is_ertn;

  assign csr_access = bus_i.csr_op != CSR_OP_NONE;
  assign csr_wr     = (bus_i.csr_op == CSR_OP_WR) || (bus_i.csr_op == CSR_OP_XCHG);
  assign csr_we     = ctl_ok && csr_wr;
  assign csr_raddr_o = bus_i.csr_num;

  // xchg merges rd into the old value where the rj mask is set
  assign csr_wdata = (bus_i.csr_op == CSR_OP_XCHG) ?
                     ((bus_i.rd_val & bus_i.rj_val) | (csr_rdata_i & ~bus_i.rj_val)) :
                     bus_i.rd_val;

  always_comb begin
    csr_commit_o                = '0;
    csr_commit_o.we             = csr_we;
    csr_commit_o.num            = bus_i.csr_num;
    csr_commit_o.wdata          = csr_wdata;
    csr_commit_o.excep          = info_i;
    csr_commit_o.excep.excep_en = excep_en;
    csr_commit_o.ertn           = ertn_en;
    csr_commit_o.pc             = bus_i.pc;
  end

  assign rf_we_o    = ctl_ok && bus_i.rf_we;
  assign rf_waddr_o = bus_i.rf_waddr;
  assign rf_wdata_o = csr_access ? csr_rdata_i : bus_i.rf_wdata;   // csr ops return old value

  // any csr write may change fetch state, so refetch after it
  assign refetch    = ctl_ok && (csr_wr || bus_i.refetch);
  assign flush_o    = excep_en || ertn_en || refetch;
  assign flush_pc_o = excep_en ? eentry_i :
                      ertn_en  ? era_i    :
                      bus_i.pc + XLEN'(4);

  assign commit_o.we    = rf_we_o;
  assign commit_o.waddr = rf_waddr_o;
  assign commit_o.wdata = rf_wdata_o;
  assign commit_o.pc    = bus_i.pc;

endmodule

// File: csr_file.sv
module csr_file #(
  parameter int XLEN    = 32,
  parameter int INT_NUM = 8
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic [INT_NUM-1:0]           int_i,
  input  logic [wb_pkg::CSR_NUM_W-1:0] raddr_i,
  output logic [XLEN-1:0]              rdata_o,
  input  wb_pkg::csr_commit_t          commit_i,
  output logic [1:0]                   plv_o,
  output logic                         int_req_o,
  output logic [XLEN-1:0]              eentry_o,
  output logic [XLEN-1:0]              era_o
);
  import wb_pkg::*;

  localparam logic [12:0] LIE_MASK = 13'h1bff;   // bit 10 reserved

  logic [1:0]            crmd_plv;
  logic                  crmd_ie;
  logic [1:0]            prmd_pplv;
  logic                  prmd_pie;
  logic [12:0]           ecfg_lie;
  logic [1:0]            estat_is_sw;   // software interrupt bits
  logic [INT_NUM-1:0]    estat_is_hw;
  ecode_e                estat_ecode;
  logic [ESUBCODE_W-1:0] estat_esubcode;
  logic [XLEN-1:0]       era;
  logic [XLEN-1:0]       badv;
  logic [XLEN-1:6]       eentry_va;     // entry is 64 byte aligned
  logic [12:0]           estat_is;
  logic [XLEN-1:0]       wdata;

  assign wdata = commit_i.wdata;

  always_comb begin
    estat_is               = '0;
    estat_is[1:0]          = estat_is_sw;
    estat_is[2 +: INT_NUM] = estat_is_hw;   // hw lines sit at IS[9:2]
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      crmd_plv       <= 2'd0;
      crmd_ie        <= 1'b0;
      prmd_pplv      <= 2'd0;
      prmd_pie       <= 1'b0;
      ecfg_lie       <= '0;
      estat_is_sw    <= '0;
      estat_ecode    <= ECODE_INT;
      estat_esubcode <= '0;
      era            <= '0;
      badv           <= '0;
      eentry_va      <= '0;
    end else if (commit_i.excep.excep_en) begin
      // exception entry, drop to kernel with interrupts off
      prmd_pplv      <= crmd_plv;
      prmd_pie       <= crmd_ie;
      crmd_plv       <= 2'd0;
      crmd_ie        <= 1'b0;
      estat_ecode    <= commit_i.excep.ecode;
      estat_esubcode <= commit_i.excep.esubcode;
      era            <= commit_i.pc;
      if (commit_i.excep.badv_we) begin
        badv <= commit_i.excep.badv;
      end
    end else if (commit_i.ertn) begin
      crmd_plv <= prmd_pplv;
      crmd_ie  <= prmd_pie;
    end else if (commit_i.we) begin
      case (commit_i.num)
        CSR_CRMD: begin
          crmd_plv <= wdata[1:0];
          crmd_ie  <= wdata[2];
        end
        CSR_PRMD: begin
          prmd_pplv <= wdata[1:0];
          prmd_pie  <= wdata[2];
        end
        CSR_ECFG:   ecfg_lie    <= wdata[12:0] & LIE_MASK;
        CSR_ESTAT:  estat_is_sw <= wdata[1:0];    // only sw bits writable
        CSR_ERA:    era         <= wdata;
        CSR_BADV:   badv        <= wdata;
        CSR_EENTRY: eentry_va   <= wdata[XLEN-1:6];
        default: ;
      endcase
    end
  end

  // hardware lines are level sampled
  always_ff @(posedge clk) begin
    if (reset_i) begin
      estat_is_hw <= '0;
    end else begin
      estat_is_hw <= int_i;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (raddr_i)
      CSR_CRMD:   rdata_o[2:0]  = {crmd_ie, crmd_plv};
      CSR_PRMD:   rdata_o[2:0]  = {prmd_pie, prmd_pplv};
      CSR_ECFG:   rdata_o[12:0] = ecfg_lie;
      CSR_ESTAT:  rdata_o       = {1'b0, estat_esubcode, estat_ecode, 3'b000, estat_is};
      CSR_ERA:    rdata_o       = era;
      CSR_BADV:   rdata_o       = badv;
      CSR_EENTRY: rdata_o       = eentry_o;
      default:    rdata_o       = '0;
    endcase
  end

  assign plv_o     = crmd_plv;
  assign int_req_o = crmd_ie && (|(estat_is & ecfg_lie));
  assign eentry_o  = {eentry_va, 6'b000000};
  assign era_o     = era;

  // writeback must pick one of entry or return per instruction
  a_excep_xor_ertn: assert property (@(posedge clk) disable iff (reset_i)
    !(commit_i.excep.excep_en && commit_i.ertn));

endmodule

// File: regfile.sv
module regfile #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 5
) (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] waddr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [ADDR_W-1:0] raddr1_i,
  input  logic [ADDR_W-1:0] raddr2_i,
  output logic [DATA_W-1:0] rdata1_o,
  output logic [DATA_W-1:0] rdata2_o
);

  logic [DATA_W-1:0] regs [2**ADDR_W];

  // writes to r0 are dropped, no writes while in reset
  always_ff @(posedge clk) begin
    if (we_i && !reset_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: wb_top.sv
module wb_top #(
  parameter int XLEN       = wb_pkg::XLEN,
  parameter int REG_ADDR_W = wb_pkg::REG_ADDR_W,
  parameter int INT_NUM    = 8
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  mw_valid_i,
  input  wb_pkg::mw_bus_t       mw_bus_i,
  output logic                  wb_allowin_o,
  input  logic                  rfb_allowin_i,
  output logic                  wb_to_rfb_valid_o,
  input  logic [INT_NUM-1:0]    int_i,
  output logic                  flush_o,
  output logic [XLEN-1:0]       flush_pc_o,
  output wb_pkg::commit_t       commit_o,
  input  logic [REG_ADDR_W-1:0] rf_raddr1_i,
  input  logic [REG_ADDR_W-1:0] rf_raddr2_i,
  output logic [XLEN-1:0]       rf_rdata1_o,
  output logic [XLEN-1:0]       rf_rdata2_o
);
  import wb_pkg::*;

  mw_bus_t               line_bus;
  excep_info_t           info;
  csr_commit_t           csr_commit;
  logic [CSR_NUM_W-1:0]  csr_raddr;
  logic [XLEN-1:0]       csr_rdata;
  logic [1:0]            plv;
  logic                  int_req;
  logic [XLEN-1:0]       eentry;
  logic [XLEN-1:0]       era;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;

  mw_line u_line (
    .clk           (clk),
    .reset_i       (reset_i),
    .mw_valid_i    (mw_valid_i),
    .mw_bus_i      (mw_bus_i),
    .rfb_allowin_i (rfb_allowin_i),
    .flush_i       (flush_o),
    .wb_allowin_o  (wb_allowin_o),
    .line_valid_o  (wb_to_rfb_valid_o),
    .line_bus_o    (line_bus)
  );

  excep_arbiter #(.XLEN(XLEN)) u_arbiter (
    .flags_i    (line_bus.excep),
    .int_req_i  (int_req),
    .is_priv_i  (line_bus.is_priv),
    .plv_i      (plv),
    .pc_i       (line_bus.pc),
    .mem_addr_i (line_bus.mem_addr),
    .info_o     (info)
  );

  wb_stage #(.XLEN(XLEN)) u_stage (
    .valid_i       (wb_to_rfb_valid_o),
    .bus_i         (line_bus),
    .rfb_allowin_i (rfb_allowin_i),
    .info_i        (info),
    .csr_rdata_i   (csr_rdata),
    .eentry_i      (eentry),
    .era_i         (era),
    .csr_raddr_o   (csr_raddr),
    .csr_commit_o  (csr_commit),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .flush_o       (flush_o),
    .flush_pc_o    (flush_pc_o),
    .commit_o      (commit_o)
  );

  csr_file #(.XLEN(XLEN), .INT_NUM(INT_NUM)) u_csr (
    .clk       (clk),
    .reset_i   (reset_i),
    .int_i     (int_i),
    .raddr_i   (csr_raddr),
    .rdata_o   (csr_rdata),
    .commit_i  (csr_commit),
    .plv_o     (plv),
    .int_req_o (int_req),
    .eentry_o  (eentry),
    .era_o     (era)
  );

  regfile #(.DATA_W(XLEN), .ADDR_W(REG_ADDR_W)) u_regfile (
    .clk      (clk),
    .reset_i  (reset_i),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .raddr1_i (rf_raddr1_i),
    .raddr2_i (rf_raddr2_i),
    .rdata1_o (rf_rdata1_o),
    .rdata2_o (rf_rdata2_o)
  );

endmodule

// File: tb_wb_tasks.svh
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

task automatic fail_run(input string why);
  $display("%s", why);
  $display(">>> FAIL");
  $fatal(1, "simulation stopped");
endtask

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
  if (expected !== actual) begin
    errors++;
    $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
    fail_run("a checked value did not match");
  end
endtask

function automatic mw_bus_t base_bus();
  mw_bus_t b;
  b      = '0;
  b.pc   = pc_next;
  b.inst = $random(seed);
  return b;
endfunction

// present on the bus and hold until the line takes it
task automatic issue(input mw_bus_t b);
  int n;
  n = 0;
  @(posedge clk);
  mw_valid_i <= 1'b1;
  mw_bus_i   <= b;
  @(negedge clk);
  while (!wb_allowin_o) begin
    n++;
    if (n > WAIT_LIMIT) fail_run("instruction was never accepted by the line");
    else @(negedge clk);
  end
  @(posedge clk);
  mw_valid_i <= 1'b0;
  pc_next = pc_next + 4;
endtask

task automatic wait_fire();
  int n;
  n = 0;
  @(negedge clk);
  while (!(wb_to_rfb_valid_o && rfb_allowin_i)) begin
    n++;
    if (n > WAIT_LIMIT) fail_run("instruction never retired from writeback");
    else @(negedge clk);
  end
  got_flush    = flush_o;
  got_flush_pc = flush_pc_o;
  got_commit   = commit_o;
endtask

task automatic exec(input mw_bus_t b);
  issue(b);
  wait_fire();
endtask

// csr instruction with rd = r1, returns the old value seen on commit
task automatic run_csr(input csr_op_e op, input logic [13:0] num, input logic [31:0] val,
                       input logic [31:0] mask, output logic [31:0] old);
  mw_bus_t b;
  b          = base_bus();
  b.csr_op   = op;
  b.csr_num  = num;
  b.rd_val   = val;
  b.rj_val   = mask;
  b.rf_we    = 1'b1;
  b.rf_waddr = 5'd1;
  exec(b);
  check("commit_o.we on csr op", 1, got_commit.we);
  check("flush_o on csr op", op != CSR_OP_RD, got_flush);
  if (op != CSR_OP_RD) check("flush_pc_o on csr write", b.pc + 4, got_flush_pc);
  old = got_commit.wdata;
endtask

task automatic read_csr(input logic [13:0] num, output logic [31:0] val);
  run_csr(CSR_OP_RD, num, '0, '0, val);
endtask

// cause and badv by the fixed priority adef sys brk ine ale adem
task automatic expect_cause(input excep_flags_t f, input logic [31:0] pc,
                            input logic [31:0] addr, output logic [31:0] estat,
                            output logic bw, output logic [31:0] bv);
  bw = 1'b1;
  bv = addr;
  if (f.adef) begin
    estat = 32'(ECODE_ADE) << 16;
    bv    = pc;
  end else if (f.sys) begin
    estat = 32'(ECODE_SYS) << 16;
    bw    = 1'b0;
  end else if (f.brk) begin
    estat = 32'(ECODE_BRK) << 16;
    bw    = 1'b0;
  end else if (f.ine) begin
    estat = 32'(ECODE_INE) << 16;
    bw    = 1'b0;
  end else if (f.ale) begin
    estat = 32'(ECODE_ALE) << 16;
  end else begin
    estat = (32'h1 << 22) | (32'(ECODE_ADE) << 16);   // adem subcode
  end
endtask

task automatic test_reg_commit();
  mw_bus_t    b;
  logic [4:0] a;
  logic [4:0] prev;
  prev = 5'd0;
  for (int i = 0; i < 8; i++) begin
    b          = base_bus();
    a          = (i == 0) ? 5'd0 : 5'($random(seed));
    b.rf_we    = 1'b1;
    b.rf_waddr = a;
    b.rf_wdata = $random(seed);
    exec(b);
    check("commit_o.we", 1, got_commit.we);
    check("commit_o.pc", b.pc, got_commit.pc);
    check("commit_o.waddr", a, got_commit.waddr);
    check("commit_o.wdata", b.rf_wdata, got_commit.wdata);
    check("flush_o", 0, got_flush);
    if (a != 5'd0) rf_model[a] = b.rf_wdata;
    @(posedge clk);
    rf_raddr1_i <= a;
    rf_raddr2_i <= prev;     // earlier write must survive
    @(negedge clk);
    check("rf_rdata1_o", rf_model[a], rf_rdata1_o);
    check("rf_rdata2_o", rf_model[prev], rf_rdata2_o);
    prev = a;
  end
endtask

task automatic test_csr_ops();
  logic [31:0] old;
  logic [31:0] v;
  logic [31:0] m;
  v = $random(seed) & 32'hffff_ffc0;
  run_csr(CSR_OP_WR, CSR_EENTRY, v, '0, old);
  check("old EENTRY", eentry_model, old);
  eentry_model = v;
  v = $random(seed);
  run_csr(CSR_OP_WR, CSR_ECFG, v, '0, old);
  check("old ECFG", ecfg_model, old);
  ecfg_model = v & LIE_BITS;
  v = $random(seed);
  m = $random(seed);
  run_csr(CSR_OP_XCHG, CSR_ECFG, v, m, old);
  check("old ECFG before xchg", ecfg_model, old);
  ecfg_model = ((v & m) | (ecfg_model & ~m)) & LIE_BITS;
  read_csr(CSR_EENTRY, old);
  check("EENTRY", eentry_model, old);
  read_csr(CSR_ECFG, old);
  check("ECFG after xchg", ecfg_model, old);
endtask

task automatic test_excep_priority();
  mw_bus_t     b;
  logic [31:0] estat;
  logic [31:0] bv;
  logic [31:0] val;
  logic        bw;
  for (int i = 0; i < 6; i++) begin
    b       = base_bus();
    b.excep = excep_flags_t'(6'($random(seed)) | 6'($random(seed)));   // dense flags
    if (b.excep == '0) b.excep.sys = 1'b1;
    b.rf_we    = 1'b1;
    b.rf_waddr = 5'd2;
    b.rf_wdata = $random(seed);
    b.mem_addr = $random(seed);
    expect_cause(b.excep, b.pc, b.mem_addr, estat, bw, bv);
    exec(b);
    check("flush_o on exception", 1, got_flush);
    check("flush_pc_o on exception", eentry_model, got_flush_pc);
    check("commit_o.we on exception", 0, got_commit.we);
    era_model = b.pc;
    if (bw) badv_model = bv;
    read_csr(CSR_ESTAT, val);
    check("ESTAT", estat, val);
    read_csr(CSR_ERA, val);
    check("ERA", era_model, val);
    read_csr(CSR_BADV, val);
    check("BADV", badv_model, val);
  end
endtask

task automatic test_priv_return();
  mw_bus_t     b;
  logic [31:0] old;
  logic [31:0] v;
  run_csr(CSR_OP_WR, CSR_PRMD, 32'h3, '0, old);   // pplv 3, pie 0
  v = $random(seed) & 32'hffff_fffc;
  run_csr(CSR_OP_WR, CSR_ERA, v, '0, old);
  check("old ERA", era_model, old);
  era_model  = v;
  b          = base_bus();
  b.is_ertn  = 1'b1;
  b.is_priv  = 1'b1;
  b.rf_we    = 1'b1;      // dropped because ertn has no register result
  b.rf_waddr = 5'd6;
  b.rf_wdata = $random(seed);
  exec(b);
  check("flush_o on ertn", 1, got_flush);
  check("flush_pc_o on ertn", era_model, got_flush_pc);
  check("commit_o.we on ertn", 0, got_commit.we);
  read_csr(CSR_CRMD, v);
  check("CRMD after ertn", 32'h3, v);
  // privileged csr read in user mode
  b          = base_bus();
  b.is_priv  = 1'b1;
  b.csr_op   = CSR_OP_RD;
  b.csr_num  = CSR_PRMD;
  b.rf_we    = 1'b1;
  b.rf_waddr = 5'd1;
  exec(b);
  check("flush_o on IPE", 1, got_flush);
  check("flush_pc_o on IPE", eentry_model, got_flush_pc);
  check("commit_o.we on IPE", 0, got_commit.we);
  era_model = b.pc;
  read_csr(CSR_ESTAT, v);
  check("ESTAT after IPE", 32'(ECODE_IPE) << 16, v);
  read_csr(CSR_PRMD, v);
  check("PRMD after IPE", 32'h3, v);
  read_csr(CSR_ERA, v);
  check("ERA after IPE", era_model, v);
  read_csr(CSR_CRMD, v);
  check("CRMD after IPE", 32'h0, v);
endtask

task automatic test_back_pressure();
  mw_bus_t a;
  mw_bus_t b;
  int      k;
  a          = base_bus();
  a.rf_we    = 1'b1;
  a.rf_waddr = 5'd3;
  a.rf_wdata = $random(seed);
  @(posedge clk);
  rfb_allowin_i <= 1'b0;
  issue(a);                // line empty, so it goes in
  b          = base_bus();
  b.rf_we    = 1'b1;
  b.rf_waddr = 5'd4;
  b.rf_wdata = $random(seed);
  @(posedge clk);
  mw_valid_i <= 1'b1;
  mw_bus_i   <= b;
  k = 1 + ($random(seed) & 7);
  repeat (k) begin
    @(negedge clk);
    check("wb_allowin_o under stall", 0, wb_allowin_o);
    check("commit_o.we under stall", 0, commit_o.we);
    check("line valid under stall", 1, wb_to_rfb_valid_o);
  end
  @(posedge clk);
  rfb_allowin_i <= 1'b1;
  @(negedge clk);
  check("first commit_o.we", 1, commit_o.we);
  check("first commit_o.pc", a.pc, commit_o.pc);
  check("first commit_o.wdata", a.rf_wdata, commit_o.wdata);
  check("wb_allowin_o on release", 1, wb_allowin_o);
  @(posedge clk);
  mw_valid_i <= 1'b0;      // second one taken at this edge
  pc_next = pc_next + 4;
  wait_fire();
  check("second commit_o.pc", b.pc, got_commit.pc);
  check("second commit_o.waddr", b.rf_waddr, got_commit.waddr);
  check("second commit_o.wdata", b.rf_wdata, got_commit.wdata);
  @(negedge clk);
  check("commit_o.we after drain", 0, commit_o.we);
  check("line valid after drain", 0, wb_to_rfb_valid_o);
endtask

task automatic test_interrupt();
  mw_bus_t     b;
  logic [31:0] v;
  logic [2:0]  line;
  line = 3'($random(seed));
  run_csr(CSR_OP_WR, CSR_ECFG, 32'h1 << (line + 2), '0, v);
  run_csr(CSR_OP_WR, CSR_CRMD, 32'h4, '0, v);   // ie on, plv 0
  @(posedge clk);
  int_i <= 8'h1 << line;
  b          = base_bus();
  b.rf_we    = 1'b1;
  b.rf_waddr = 5'd5;
  b.rf_wdata = $random(seed);
  exec(b);
  check("flush_o on interrupt", 1, got_flush);
  check("flush_pc_o on interrupt", eentry_model, got_flush_pc);
  check("commit_o.we on interrupt", 0, got_commit.we);
  read_csr(CSR_ERA, v);
  check("ERA after interrupt", b.pc, v);
  read_csr(CSR_ESTAT, v);
  check("ESTAT after interrupt", 32'h1 << (line + 2), v);
  // entry cleared ie, so the line stays pending but is not taken
  b          = base_bus();
  b.rf_we    = 1'b1;
  b.rf_waddr = 5'd5;
  b.rf_wdata = $random(seed);
  exec(b);
  check("flush_o with ie clear", 0, got_flush);
  check("commit_o.we with ie clear", 1, got_commit.we);
  check("commit_o.wdata with ie clear", b.rf_wdata, got_commit.wdata);
  @(posedge clk);
  int_i <= '0;
endtask

`endif

// File: tb_wb_top.sv
module tb_wb_top;
  import wb_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int MAX_INSTS  = 60;     // upper bound on instructions over all tests
  localparam int MARGIN     = 20;     // cycles allowed per instruction
  localparam int WAIT_LIMIT = 40;
  localparam logic [31:0] LIE_BITS = 32'h1bff;   // lie is 12:11 and 9:0

  logic                  clk;
  logic                  reset_i;
  logic                  mw_valid_i;
  mw_bus_t               mw_bus_i;
  logic                  wb_allowin_o;
  logic                  rfb_allowin_i;
  logic                  wb_to_rfb_valid_o;
  logic [7:0]            int_i;
  logic                  flush_o;
  logic [XLEN-1:0]       flush_pc_o;
  commit_t               commit_o;
  logic [REG_ADDR_W-1:0] rf_raddr1_i;
  logic [REG_ADDR_W-1:0] rf_raddr2_i;
  logic [XLEN-1:0]       rf_rdata1_o;
  logic [XLEN-1:0]       rf_rdata2_o;

  integer      seed;
  int          errors;
  logic [31:0] pc_next;

  // outputs captured in the fire cycle
  logic        got_flush;
  logic [31:0] got_flush_pc;
  commit_t     got_commit;

  // expected architectural state
  logic [31:0] rf_model [32];
  logic [31:0] eentry_model;
  logic [31:0] ecfg_model;
  logic [31:0] era_model;
  logic [31:0] badv_model;

  wb_top #(
    .XLEN       (XLEN),
    .REG_ADDR_W (REG_ADDR_W),
    .INT_NUM    (8)
  ) UUT (
    .clk               (clk),
    .reset_i           (reset_i),
    .mw_valid_i        (mw_valid_i),
    .mw_bus_i          (mw_bus_i),
    .wb_allowin_o      (wb_allowin_o),
    .rfb_allowin_i     (rfb_allowin_i),
    .wb_to_rfb_valid_o (wb_to_rfb_valid_o),
    .int_i             (int_i),
    .flush_o           (flush_o),
    .flush_pc_o        (flush_pc_o),
    .commit_o          (commit_o),
    .rf_raddr1_i       (rf_raddr1_i),
    .rf_raddr2_i       (rf_raddr2_i),
    .rf_rdata1_o       (rf_rdata1_o),
    .rf_rdata2_o       (rf_rdata2_o)
  );

  `include "tb_wb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(MAX_INSTS * MARGIN * CLK_PERIOD);
    fail_run("watchdog expired before the test sequence finished");
  end

  initial begin : main
    seed          = 32'h68fb3288;
    errors        = 0;
    pc_next       = 32'h1c00_0000;   // reset vector style start
    eentry_model  = '0;
    ecfg_model    = '0;
    era_model     = '0;
    badv_model    = '0;
    foreach (rf_model[i]) rf_model[i] = '0;
    reset_i       = 1'b1;
    mw_valid_i    = 1'b0;
    mw_bus_i      = '0;
    rfb_allowin_i = 1'b1;
    int_i         = '0;
    rf_raddr1_i   = '0;
    rf_raddr2_i   = '0;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check("line valid after reset", 0, wb_to_rfb_valid_o);
    check("flush_o after reset", 0, flush_o);
    check("commit_o.we after reset", 0, commit_o.we);

    test_reg_commit();
    test_csr_ops();
    test_excep_priority();
    test_priv_return();
    test_back_pressure();
    test_interrupt();

    if (errors == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      fail_run("errors were counted during the run");
    end
  end

endmodule

// File: verilog.f
+incdir+.
wb_pkg.sv
mw_line.sv
excep_arbiter.sv
wb_stage.sv
csr_file.sv
regfile.sv
wb_top.sv
tb_wb_top.sv

// File: Bender.yml
package:
  name: wb_writeback

sources:
  - files:
      - wb_pkg.sv
      - mw_line.sv
      - excep_arbiter.sv
      - wb_stage.sv
      - csr_file.sv
      - regfile.sv
      - wb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wb_top.sv
